// ==== Makefile ====
# Verilator build and run for the cartridge bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_cart_top
FILELIST  ?= cart_vdp.f
OBJ_DIR   ?= ./obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit status
run: compile
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cart_vdp.f ====
source/cart_pkg.sv
source/msx_bus_bridge.sv
source/vdp_port_regs.sv
source/vram_ctrl.sv
source/cart_status.sv
source/tang_cart_top.sv
verif/cart_top_sva.sv
verif/tb_cart_top.sv

// ==== source/cart_pkg.sv ====
/* Shared types and constants for the cartridge bridge:
   port and memory request structs, port numbers, register indices */
package cart_pkg;

	// --------------------
	// Request payloads
	// --------------------

	// One host access toward the port block
	typedef struct packed {
		logic		wr;		// 1 = write
		logic [1:0]	port;	// Port number from ta
		logic [7:0]	wdata;	// Host write byte
	} port_req_t;

	// One video memory access
	typedef struct packed {
		logic		wr;		// 1 = write
		logic [16:0]	addr;	// Byte address, 128K space
		logic [7:0]	wdata;
	} vram_req_t;

	// --------------------
	// Port and register map
	// --------------------
	localparam logic [1:0] PORT_DATA = 2'd0;	// VRAM data, auto increment
	localparam logic [1:0] PORT_CTRL = 2'd1;	// Two byte register / pointer setup

	// Register whose low nibble picks the port 1 read-back
	localparam logic [3:0] REG_STATUS_SEL = 4'd15;

	// Register holding pointer bits 16..14
	localparam logic [3:0] REG_ADDR_HIGH = 4'd14;

	// Ports 2 and 3 float high on a read
	localparam logic [7:0] UNUSED_READ = 8'hFF;

endpackage

// ==== source/cart_status.sv ====
/* Startup wait timer and heartbeat LED counter */
`timescale 1ns/1ps

module cart_status #(
	parameter int WAIT_CYCLES  = 64,	// Host held off this long
	parameter int BLINK_CYCLES = 27_000_000	// LED step period
) (
	input  logic		clk,
	input  logic		w_n_reset,
	output logic		startup_wait,
	output logic [1:0]	led
);

	localparam int WAIT_W  = $clog2(WAIT_CYCLES + 1);
	localparam int BLINK_W = $clog2(BLINK_CYCLES);

	logic [WAIT_W-1:0]	wait_cnt;
	logic [BLINK_W-1:0]	blink_cnt;

	// --------------------
	// Startup wait
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			wait_cnt     <= '0;
			startup_wait <= 1'b1;
		end else if (wait_cnt != WAIT_W'(WAIT_CYCLES - 1)) begin
			wait_cnt <= wait_cnt + 1'b1;	// Saturates at WAIT_CYCLES - 1
		end else begin
			startup_wait <= 1'b0;
		end
	end

	// Heartbeat, wraps every period
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			blink_cnt <= '0;
			led       <= 2'd0;
		end else if (blink_cnt == BLINK_W'(BLINK_CYCLES - 1)) begin
			blink_cnt <= '0;
			led       <= led + 2'd1;
		end else begin
			blink_cnt <= blink_cnt + 1'b1;
		end
	end

endmodule

// ==== source/msx_bus_bridge.sv ====
/* Host bus bridge: strobe synchronizer, access detect, port request
   hold until ack, wait line and read data return */
`timescale 1ns/1ps

module msx_bus_bridge (
	input  logic			clk,
	input  logic			w_n_reset,
	input  logic			n_ce,
	input  logic			n_twr,
	input  logic			n_trd,
	input  logic [1:0]		ta,
	input  logic [7:0]		td_in,
	output logic [7:0]		td_out,
	output logic			tdir,
	output logic			twait,
	input  logic			startup_wait,
	output logic			port_req_valid,
	output cart_pkg::port_req_t	port_req,
	input  logic			port_ack,
	input  logic [7:0]		port_rdata
);

	// Host pins sampled as one group
	typedef struct packed {
		logic		n_ce;
		logic		n_twr;
		logic		n_trd;
		logic [1:0]	ta;
		logic [7:0]	td;
	} host_bus_t;

	host_bus_t	bus_s1;		// First sync stage
	host_bus_t	bus_s2;		// Second sync stage, safe to use
	logic		access;
	logic		access_d;
	logic		rd_active;
	logic		start;

	// --------------------
	// Synchronizer
	// --------------------
	always_ff @(posedge clk) begin
		bus_s1 <= '{n_ce: n_ce, n_twr: n_twr, n_trd: n_trd, ta: ta, td: td_in};
		bus_s2 <= bus_s1;
	end

	assign rd_active = ~bus_s2.n_ce & ~bus_s2.n_trd;
	assign access    = rd_active | (~bus_s2.n_ce & ~bus_s2.n_twr);
	assign start     = access & ~access_d;	// Rising edge only, host must release first

	// --------------------
	// Request hold
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			access_d       <= 1'b1;	// No false edge out of reset
			port_req_valid <= 1'b0;
		end else begin
			access_d <= access;
			if (port_req_valid && port_ack)
				port_req_valid <= 1'b0;
			else if (start && !port_req_valid)
				port_req_valid <= 1'b1;
		end
	end

	// Payload captured once per access
	always_ff @(posedge clk) begin
		if (start && !port_req_valid) begin
			port_req.wr    <= ~bus_s2.n_twr;
			port_req.port  <= bus_s2.ta;
			port_req.wdata <= bus_s2.td;
		end
	end

	// --------------------
	// Read data return
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			tdir <= 1'b0;
		end else if (port_req_valid && port_ack && !port_req.wr) begin
			tdir <= 1'b1;	// Drive bus with the ack data
		end else if (!rd_active) begin
			tdir <= 1'b0;	// Host let go of the read
		end
	end

	always_ff @(posedge clk) begin
		if (port_req_valid && port_ack && !port_req.wr)
			td_out <= port_rdata;
	end

	// Wait the host during startup or while the port block is busy
	assign twait = startup_wait | port_req_valid;

endmodule

// ==== source/tang_cart_top.sv ====
/* Cartridge top: host bridge, VDP port block, VRAM controller, status */
`timescale 1ns/1ps

module tang_cart_top #(
	parameter int VRAM_DEPTH_BITS = 17,
	parameter int INIT_CYCLES     = 32,
	parameter int READ_LATENCY    = 3,
	parameter int WAIT_CYCLES     = 64,
	parameter int BLINK_CYCLES    = 27_000_000
) (
	input  logic		clk,
	input  logic		w_n_reset,
	input  logic		n_ce,
	input  logic		n_twr,
	input  logic		n_trd,
	input  logic [1:0]	ta,
	input  logic [7:0]	td_in,
	output logic [7:0]	td_out,
	output logic		tdir,
	output logic		twait,
	output logic [1:0]	led
);

	logic			startup_wait;
	logic			port_req_valid;
	cart_pkg::port_req_t	port_req;
	logic			port_ack;
	logic [7:0]		port_rdata;
	logic			mem_req_valid;
	cart_pkg::vram_req_t	mem_req;
	logic			mem_busy;
	logic			mem_done;
	logic [7:0]		mem_rdata;

	msx_bus_bridge u_bridge (
		.clk, .w_n_reset, .n_ce, .n_twr, .n_trd, .ta, .td_in,
		.td_out, .tdir, .twait, .startup_wait,
		.port_req_valid, .port_req, .port_ack, .port_rdata
	);

	vdp_port_regs u_vdp (
		.clk, .w_n_reset, .port_req_valid, .port_req, .port_ack, .port_rdata,
		.mem_req_valid, .mem_req, .mem_busy, .mem_done, .mem_rdata
	);

	vram_ctrl #(
		.DEPTH_BITS   (VRAM_DEPTH_BITS),
		.INIT_CYCLES  (INIT_CYCLES),
		.READ_LATENCY (READ_LATENCY)
	) u_vram (
		.clk, .w_n_reset, .mem_req_valid, .mem_req, .mem_busy, .mem_done, .mem_rdata
	);

	cart_status #(
		.WAIT_CYCLES  (WAIT_CYCLES),
		.BLINK_CYCLES (BLINK_CYCLES)
	) u_status (
		.clk, .w_n_reset, .startup_wait, .led
	);

endmodule

// ==== source/vdp_port_regs.sv ====
/* VDP style port block: two-byte control latch, 16 control registers,
   auto-increment VRAM pointer and memory access sequencing */
`timescale 1ns/1ps

module vdp_port_regs (
	input  logic			clk,
	input  logic			w_n_reset,
	input  logic			port_req_valid,
	input  cart_pkg::port_req_t	port_req,
	output logic			port_ack,
	output logic [7:0]		port_rdata,
	output logic			mem_req_valid,
	output cart_pkg::vram_req_t	mem_req,
	input  logic			mem_busy,
	input  logic			mem_done,
	input  logic [7:0]		mem_rdata
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_MEM_WAIT,	// Waiting for mem_busy low
		S_MEM_RUN	// Request out, waiting for mem_done
	} state_t;

	state_t		state;
	logic [7:0]	regs [16];
	logic [7:0]	first_byte;	// Latched first write on port 1
	logic		second_byte;	// High once the first byte is in
	logic [16:0]	pointer;
	logic		reg_ack;
	logic [7:0]	rdata_q;
	logic		mem_ack;
	logic		new_req;

	assign new_req = port_req_valid && !reg_ack && (state == S_IDLE);

	// --------------------
	// Port decode
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			state       <= S_IDLE;
			reg_ack     <= 1'b0;
			second_byte <= 1'b0;
			pointer     <= '0;
			for (int i = 0; i < 16; i++)
				regs[i] <= 8'h00;
		end else begin
			reg_ack <= 1'b0;
			case (state)
				S_IDLE: if (new_req) begin
					if (port_req.port == cart_pkg::PORT_DATA) begin
						state <= S_MEM_WAIT;
					end else begin
						reg_ack <= 1'b1;	// One cycle turnaround
						if (port_req.port == cart_pkg::PORT_CTRL) begin
							if (!port_req.wr) begin
								second_byte <= 1'b0;	// Read resets sequence
							end else if (!second_byte) begin
								second_byte <= 1'b1;
							end else begin
								second_byte <= 1'b0;
								if (port_req.wdata[7])
									regs[port_req.wdata[3:0]] <= first_byte;
								else
									pointer <= {regs[cart_pkg::REG_ADDR_HIGH][2:0],
										port_req.wdata[5:0], first_byte};
							end
						end
					end
				end
				S_MEM_WAIT: if (!mem_busy) state <= S_MEM_RUN;
				S_MEM_RUN: if (mem_done) begin
					state   <= S_IDLE;
					pointer <= pointer + 17'd1;	// Auto increment
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// First byte and read-back data carry no reset
	always_ff @(posedge clk) begin
		if (new_req && port_req.port == cart_pkg::PORT_CTRL && port_req.wr && !second_byte)
			first_byte <= port_req.wdata;
		if (new_req)
			rdata_q <= (port_req.port == cart_pkg::PORT_CTRL)
				? regs[regs[cart_pkg::REG_STATUS_SEL][3:0]]
				: cart_pkg::UNUSED_READ;
	end

	// --------------------
	// Memory side
	// --------------------
	assign mem_req_valid = (state == S_MEM_WAIT) && !mem_busy;	// Single cycle strobe
	assign mem_req       = '{wr: port_req.wr, addr: pointer, wdata: port_req.wdata};

	// Port 0 acks straight off mem_done
	assign mem_ack    = (state == S_MEM_RUN) && mem_done;
	assign port_ack   = reg_ack | mem_ack;
	assign port_rdata = mem_ack ? mem_rdata : rdata_q;

endmodule

// ==== source/vram_ctrl.sv ====
/* Video memory model: byte array with startup busy period
   and fixed latency single access */
`timescale 1ns/1ps

module vram_ctrl #(
	parameter int DEPTH_BITS   = 17,
	parameter int INIT_CYCLES  = 32,	// Busy cycles after reset, at least 1
	parameter int READ_LATENCY = 3		// Strobe to done, at least 1
) (
	input  logic			clk,
	input  logic			w_n_reset,
	input  logic			mem_req_valid,
	input  cart_pkg::vram_req_t	mem_req,
	output logic			mem_busy,
	output logic			mem_done,
	output logic [7:0]		mem_rdata
);

	localparam int INIT_W = $clog2(INIT_CYCLES + 1);
	localparam int LAT_W  = $clog2(READ_LATENCY + 1);

	logic [7:0]		mem [2**DEPTH_BITS];
	logic [INIT_W-1:0]	init_cnt;
	logic			init_busy;
	logic [LAT_W-1:0]	lat_cnt;	// Cycles left until done
	logic			active;
	logic			finish;
	cart_pkg::vram_req_t	req_q;

	// --------------------
	// Startup and latency
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			init_cnt  <= '0;
			init_busy <= 1'b1;
			lat_cnt   <= '0;
			active    <= 1'b0;
			mem_done  <= 1'b0;
		end else begin
			if (init_busy) begin
				init_cnt <= init_cnt + 1'b1;
				if (init_cnt == INIT_W'(INIT_CYCLES - 1))
					init_busy <= 1'b0;
			end
			mem_done <= finish;
			if (mem_req_valid && !mem_busy) begin
				lat_cnt <= LAT_W'(READ_LATENCY - 1);
				active  <= (READ_LATENCY > 1);
			end else if (active) begin
				lat_cnt <= lat_cnt - 1'b1;
				if (lat_cnt == LAT_W'(1))
					active <= 1'b0;
			end
		end
	end

	// Done lands READ_LATENCY cycles after the strobe
	assign finish = (READ_LATENCY == 1) ? (mem_req_valid && !mem_busy)
		: (active && lat_cnt == LAT_W'(1));

	assign mem_busy = init_busy | active | mem_done;

	// --------------------
	// Array access
	// --------------------
	always_ff @(posedge clk) begin
		if (mem_req_valid && !mem_busy)
			req_q <= mem_req;
	end

	// Low address bits only, upper ones alias
	always_ff @(posedge clk) begin
		if (finish && ((READ_LATENCY == 1) ? mem_req.wr : req_q.wr))
			mem[(READ_LATENCY == 1) ? mem_req.addr[DEPTH_BITS-1:0]
				: req_q.addr[DEPTH_BITS-1:0]] <= (READ_LATENCY == 1) ? mem_req.wdata : req_q.wdata;
		if (finish)
			mem_rdata <= mem[(READ_LATENCY == 1) ? mem_req.addr[DEPTH_BITS-1:0]
				: req_q.addr[DEPTH_BITS-1:0]];
	end

endmodule

// ==== verif/cart_top_sva.sv ====
/* Bound checks on the host bridge: request hold, ack pairing, wait line */
`timescale 1ns/1ps

module cart_top_sva (
	input  logic			clk,
	input  logic			w_n_reset,
	input  logic			startup_wait,
	input  logic			port_req_valid,
	input  cart_pkg::port_req_t	port_req,
	input  logic			port_ack,
	input  logic			twait
);

	// --------------------
	// Port handshake
	// --------------------

	// Request and payload held until the ack
	a_req_hold: assert property (@(posedge clk) disable iff (!w_n_reset)
		port_req_valid && !port_ack |=> port_req_valid && $stable(port_req))
		else $error("port request dropped or changed before ack");

	a_ack_with_req: assert property (@(posedge clk) disable iff (!w_n_reset)
		port_ack |-> port_req_valid)	// No stray ack
		else $error("port ack without a pending request");

	// Host let go in the cycle after the ack, once startup is over
	a_wait_release: assert property (@(posedge clk) disable iff (!w_n_reset)
		port_req_valid && port_ack && !startup_wait |=> !twait)
		else $error("twait still high in the cycle after the port ack");

endmodule

bind msx_bus_bridge cart_top_sva u_sva (.*);

// ==== verif/cart_trace.txt ====
startup_reg5_lo W 1 3C 00
reg5_hi W 1 85 00
sel_lo W 1 05 00
sel_hi W 1 8F 00
reg5_read R 1 00 3C
ptr10_lo W 1 10 00
ptr10_hi W 1 40 00
vram_wr0 W 0 11 00
vram_wr1 W 0 22 00
vram_wr2 W 0 33 00
vram_wr3 W 0 44 00
ptr10b_lo W 1 10 00
ptr10b_hi W 1 00 00
vram_rd0 R 0 00 11
vram_rd1 R 0 00 22
vram_rd2 R 0 00 33
vram_rd3 R 0 00 44
r14_lo W 1 00 00
r14_hi W 1 8E 00
alias_ptr_lo W 1 05 00
alias_ptr_hi W 1 41 00
alias_wr W 0 A5 00
alias_rd_ptr_lo W 1 05 00
alias_rd_ptr_hi W 1 00 00
alias_rd R 0 00 A5
port2_read R 2 00 FF
port3_read R 3 00 FF
port2_write W 2 77 00
reg5_after R 1 00 3C
recheck_ptr_lo W 1 05 00
recheck_ptr_hi W 1 00 00
recheck_rd R 0 00 A5
heartbeat L 0 05 01

// ==== verif/tb_cart_top.sv ====
/* Trace driven testbench for the cartridge top: host bus cycles,
   read data compare, startup wait and heartbeat LED checks */
`timescale 1ns/1ps

module tb_cart_top;

	localparam int DEPTH_BITS = 8;		// 256 byte VRAM, upper bits alias
	localparam int BLINK_CYC  = 16;
	localparam int WAIT_CYC   = 64;		// Startup hold of the host
	localparam int SYNC_CYC   = 3;		// Two sync flops plus edge detect
	localparam int STEP_LIMIT = 500;	// Cycles allowed for any single wait
	localparam int SEED       = 52534;

	logic		clk;
	logic		w_n_reset;
	logic		n_ce;
	logic		n_twr;
	logic		n_trd;
	logic [1:0]	ta;
	logic [7:0]	td_in;
	logic [7:0]	td_out;
	logic		tdir;
	logic		twait;
	logic [1:0]	led;
	logic		aborted;	// Timeout or missing trace
	string		cur_test;

	tang_cart_top #(
		.VRAM_DEPTH_BITS (DEPTH_BITS),
		.WAIT_CYCLES     (WAIT_CYC),
		.BLINK_CYCLES    (BLINK_CYC)
	) dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------
	// Bus helpers
	// --------------------

	// Waits on falling edges for twait to reach level
	task automatic wait_for_twait(input logic level, output int cycles);
		cycles = 0;
		while (twait !== level && cycles < STEP_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (twait !== level) begin
			$display("%0s: twait never went to %0d", cur_test, level);
			aborted = 1'b1;
		end
	endtask

	// One host access, entered and left on a falling edge
	task automatic bus_cycle(input logic wr, input logic [1:0] port, input logic [7:0] data,
			output logic [7:0] rdata, output logic rdir, output int high_cycles);
		int n;
		int gap;
		high_cycles = 0;
		n_ce  = 1'b0;
		n_twr = ~wr;
		n_trd = wr;
		ta    = port;
		td_in = data;
		wait_for_twait(1'b1, n);
		if (!aborted)
			wait_for_twait(1'b0, high_cycles);	// Ack seen, data settled
		rdata = td_out;
		rdir  = tdir;
		n_ce  = 1'b1;
		n_twr = 1'b1;
		n_trd = 1'b1;
		n = 0;
		while (tdir !== 1'b0 && n < STEP_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (tdir !== 1'b0) begin
			$display("%0s: tdir stayed high after the read was released", cur_test);
			aborted = 1'b1;
		end
		gap = SYNC_CYC + 1 + int'($urandom % 4);	// Release must pass the sync
		repeat (gap) @(negedge clk);
	endtask

	// Each LED change must be the previous value plus incr
	task automatic check_led_steps(input int steps, input logic [1:0] incr, output int errs);
		logic [1:0]	prev;
		int		n;
		errs = 0;
		prev = led;
		for (int i = 0; i < steps && !aborted; i++) begin
			n = 0;
			while (led === prev && n < 4 * BLINK_CYC) begin
				@(negedge clk);
				n++;
			end
			if (led === prev) begin
				$display("%0s: led stuck at %0d", cur_test, prev);
				aborted = 1'b1;
			end else if (led !== prev + incr) begin
				$display("ERROR %0s: expected %0d actual %0d", cur_test, prev + incr, led);
				errs++;
			end
			prev = led;
		end
	endtask

	// --------------------
	// Trace runner
	// --------------------
	initial begin
		int		fd;
		int		fields;
		int		errs;
		int		high;
		int		bus_count;
		int		test_count;
		int		fail_count;
		logic [8*24-1:0]	name;
		logic [7:0]	op;
		logic [1:0]	port;
		logic [7:0]	data;
		logic [7:0]	expect_v;
		logic [7:0]	rdata;
		logic		rdir;

		void'($urandom(SEED));
		aborted    = 1'b0;
		bus_count  = 0;
		test_count = 0;
		fail_count = 0;
		w_n_reset  = 1'b0;
		n_ce       = 1'b1;
		n_twr      = 1'b1;
		n_trd      = 1'b1;
		ta         = 2'd0;
		td_in      = 8'h00;
		repeat (2) @(negedge clk);
		w_n_reset = 1'b1;	// First access starts inside the startup hold

		fd = $fopen("verif/cart_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open trace file verif/cart_trace.txt");
			aborted = 1'b1;
		end
		fields = (fd != 0) ? $fscanf(fd, " %s %s %h %h %h", name, op, port, data, expect_v) : 0;
		while (fields == 5 && !aborted) begin
			cur_test = $sformatf("%0s", name);
			errs = 0;
			if (op == "L") begin
				check_led_steps(int'(data), expect_v[1:0], errs);	// data = steps
			end else begin
				bus_cycle(op == "W", port, data, rdata, rdir, high);
				if (bus_count == 0 && high < WAIT_CYC) begin
					$display("ERROR %0s: expected twait high >= %0d cycles actual %0d",
						cur_test, WAIT_CYC, high);
					errs++;
				end
				bus_count++;
				if (op == "R" && !aborted) begin
					if (rdata !== expect_v) begin
						$display("ERROR %0s: expected %02h actual %02h", cur_test, expect_v, rdata);
						errs++;
					end
					if (rdir !== 1'b1) begin
						$display("%0s: tdir was low while read data was returned", cur_test);
						errs++;
					end
				end
			end
			if (aborted)
				errs++;
			test_count++;
			if (errs == 0) begin
				$display("test %0s ok", cur_test);
			end else begin
				fail_count++;
				$display("test %0s failed with %0d errors", cur_test, errs);
			end
			fields = $fscanf(fd, " %s %s %h %h %h", name, op, port, data, expect_v);
		end
		if (fd != 0)
			$fclose(fd);

		$display("tests run %0d, passed %0d, failed %0d",
			test_count, test_count - fail_count, fail_count);
		if (fail_count == 0 && !aborted && test_count > 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
